/* files.f */
common/gpu_spi_pkg.sv
common/spi_phase_if.sv
rtl/nibble_deser.sv
rtl/nibble_ser.sv
rtl/spi_link.sv
rtl/palette/palette_port.sv
rtl/pixel_writer.sv
rtl/status_ctrl.sv
rtl/spi_gpu_top.sv
verif/spi_gpu_props.sv
verif/spi_gpu_tb.sv

/* verif/spi_gpu_tb.sv */
module spi_gpu_tb;
    import gpu_spi_pkg::*;

    localparam int FRAME_PIXELS  = 76800;
    localparam int DUMMY_CYCLES  = 2;
    localparam int STATUS_ROUNDS = 6;
    localparam int IDLE_GAP      = 3;
    localparam int TXN_GAP       = 1 + IDLE_GAP;    // cs-high edge plus idle cycles
    localparam logic [4:0] TAG   = 5'b10110;
    localparam int COLOR_NIBS    = 6;
    // cycles of every transaction below, worst case of the random lengths
    localparam int RUN_CYCLES = 2 + 8
        + STATUS_ROUNDS * (2 + TXN_GAP + 4 + DUMMY_CYCLES + TXN_GAP)
        + (2 + PAL_NIBBLES + TXN_GAP) + (2 + DUMMY_CYCLES + PAL_NIBBLES + TXN_GAP)
        + (8 + 2 * 12 + TXN_GAP) + (2 + 6 * COLOR_NIBS + 5 + TXN_GAP) + (12 + TXN_GAP);

    logic       sclk;
    logic       rst;
    logic       cs;
    logic [3:0] data_in;
    logic [3:0] data_out;
    logic       data_oe;
    rgb_addr_t  rgb_addr;
    pixel_t     rgb_data;
    logic       rgb_wren;
    pal_addr_t  pal_addr;
    color_t     pal_wdata;
    logic       pal_wren;
    color_t     pal_rdata;
    logic       hblank;
    logic       vblank;

    logic [31:0] rng;
    color_t      pal_mem [PAL_ENTRIES];  // external palette RAM
    color_t      colors [PAL_ENTRIES];
    logic [3:0]  nib_q[$];               // nibbles of the next transaction
    logic [3:0]  tx_q[$];                // nibbles seen while data_oe is high
    rgb_addr_t   fb_addr_q[$];
    pixel_t      fb_data_q[$];
    pal_addr_t   pw_addr_q[$];
    color_t      pw_data_q[$];

    spi_gpu_top #(
        .FRAME_PIXELS(FRAME_PIXELS),
        .DUMMY_CYCLES(DUMMY_CYCLES)
    ) uut (
        .sclk      (sclk),
        .rst       (rst),
        .cs        (cs),
        .data_in   (data_in),
        .data_out  (data_out),
        .data_oe   (data_oe),
        .rgb_addr  (rgb_addr),
        .rgb_data  (rgb_data),
        .rgb_wren  (rgb_wren),
        .pal_addr  (pal_addr),
        .pal_wdata (pal_wdata),
        .pal_wren  (pal_wren),
        .pal_rdata (pal_rdata),
        .hblank    (hblank),
        .vblank    (vblank)
    );

    always #2 sclk = ~sclk;

    // RAM answers one cycle late, writes land on the same edge
    always @(posedge sclk)
    begin
        pal_rdata <= pal_mem[pal_addr];
        if (pal_wren)
            pal_mem[pal_addr] <= pal_wdata;
    end

    // scoreboard logs, sampled before the edge updates anything
    always @(posedge sclk)
    begin
        if (data_oe)
            tx_q.push_back(data_out);
        if (rgb_wren)
        begin
            fb_addr_q.push_back(rgb_addr);
            fb_data_q.push_back(rgb_data);
        end
        if (pal_wren)
        begin
            pw_addr_q.push_back(pal_addr);
            pw_data_q.push_back(pal_wdata);
        end
    end

    function logic [31:0] rand_next();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task check_value(input logic [31:0] expected, input logic [31:0] actual, input string what);
        if (expected !== actual)
        begin
            $display("Mismatch at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    task push_value(input logic [31:0] value, input int nibbles);
        for (int i = nibbles - 1; i >= 0; i--)
            nib_q.push_back(value[4 * i +: 4]);  // high nibble first
    endtask

    task clear_logs();
        tx_q.delete();
        fb_addr_q.delete();
        fb_data_q.delete();
        pw_addr_q.delete();
        pw_data_q.delete();
    endtask

    // drive queued nibbles with cs low, then deselect and idle
    task run_txn();
        clear_logs();
        while (nib_q.size() > 0)
        begin
            @(posedge sclk);
            cs      <= 1'b0;
            data_in <= nib_q.pop_front();
        end
        @(posedge sclk);
        cs      <= 1'b1;
        data_in <= '0;
        repeat (IDLE_GAP) @(posedge sclk);
    endtask

    task check_palette_writes(input int count);
        check_value(count, pw_addr_q.size(), "palette write count");
        for (int i = 0; i < pw_addr_q.size(); i++)
        begin
            check_value(i, pw_addr_q[i], "palette write address");
            check_value(colors[i], pw_data_q[i], "palette write data");
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic        enabled;
        logic [7:0]  status;
        color_t      c;
        int          start;
        int          count;
        int          part;
        rgb_addr_t   a;
        pixel_t      pix[$];

        sclk      = 1'b0;
        rst       = 1'b1;
        cs        = 1'b1;
        data_in   = '0;
        pal_rdata = '0;
        hblank    = 1'b0;
        vblank    = 1'b0;
        rng       = 32'hb3e9_26f9;
        enabled   = 1'b0;
        for (int i = 0; i < PAL_ENTRIES; i++)
            pal_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
        repeat (2) @(posedge sclk);
        rst <= 1'b0;

        // idle bus with cs high
        clear_logs();
        repeat (8) @(posedge sclk);
        check_value(0, tx_q.size() + fb_addr_q.size() + pw_addr_q.size(), "activity while idle");

        for (int n = 0; n < STATUS_ROUNDS; n++)
        begin
            r = rand_next();
            push_value(r[0] ? CMD_ENABLE_OUTPUT : CMD_DISABLE_OUTPUT, 2);
            run_txn();
            enabled = r[0];
            hblank <= r[1];
            vblank <= r[2];
            push_value(CMD_READ_STATUS0, 2);
            push_value(0, DUMMY_CYCLES + 2);
            run_txn();
            status = {TAG, r[1], r[2], enabled};
            check_value(2, tx_q.size(), "status nibble count");
            check_value(status[7:4], tx_q[0], "status high nibble");
            check_value(status[3:0], tx_q[1], "status low nibble");
        end

        // palette set then read back
        push_value(CMD_PAL_SET, 2);
        for (int i = 0; i < PAL_ENTRIES; i++)
        begin
            r = rand_next();
            colors[i] = r[23:0];
            push_value(colors[i], COLOR_NIBS);
        end
        run_txn();
        check_palette_writes(PAL_ENTRIES);
        push_value(CMD_PAL_GET, 2);
        for (int i = 0; i < DUMMY_CYCLES + PAL_NIBBLES; i++)
            nib_q.push_back(4'h0);
        run_txn();
        check_value(PAL_NIBBLES, tx_q.size(), "palette get nibble count");
        for (int i = 0; i < tx_q.size(); i++)
        begin
            c = colors[i / COLOR_NIBS];
            check_value(c[4 * (COLOR_NIBS - 1 - i % COLOR_NIBS) +: 4], tx_q[i], "palette get nibble");
        end
        check_value(0, pw_addr_q.size(), "palette write during get");

        // pixel write across the end of the frame, long enough to always wrap
        r = rand_next();
        start = FRAME_PIXELS - 1 - int'(r[1:0]);
        count = 5 + int'(r[4:2]);
        push_value(CMD_FB_WRITE, 2);
        push_value(start, 6);
        for (int i = 0; i < count; i++)
        begin
            r = rand_next();
            pix.push_back(r[7:0]);
            push_value(r[7:0], 2);
        end
        run_txn();
        check_value(count, fb_addr_q.size(), "pixel write count");
        a = start;
        for (int i = 0; i < fb_addr_q.size(); i++)
        begin
            check_value(a, fb_addr_q[i], "pixel write address");
            check_value(pix[i], fb_data_q[i], "pixel write data");
            a = (a == FRAME_PIXELS - 1) ? '0 : a + 1'b1;
        end

        // palette set cut short by cs
        r = rand_next();
        count = 1 + int'(r[2:0] % 6);
        part = 1 + int'(r[7:4] % 5);
        push_value(CMD_PAL_SET, 2);
        for (int i = 0; i < count; i++)
        begin
            r = rand_next();
            colors[i] = r[23:0];
            push_value(colors[i], COLOR_NIBS);
        end
        push_value(rand_next(), part);
        run_txn();
        check_palette_writes(count);

        push_value(8'h55, 2);  // no such command
        push_value(rand_next(), 8);
        push_value(rand_next(), 2);
        run_txn();
        check_value(0, tx_q.size() + fb_addr_q.size() + pw_addr_q.size(), "undefined command");

        if (uut.u_props.fail_count != 0)
        begin
            $display("Assertion failure: a bound property did not hold");
            $display("Test failures found");
            $fatal(1, "property failed");
        end
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial
    begin
        wait (uut.u_props.fail_count != 0);
        $display("Assertion failure: a bound property did not hold at %0t", $time);
        $display("Test failures found");
        $fatal(1, "property failed");
    end

    initial
    begin
        #((RUN_CYCLES + 100) * 4);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verif/spi_gpu_props.sv */
module spi_gpu_props (
    input logic sclk,
    input logic rst,
    input logic cs,
    input logic data_oe,
    input logic rgb_wren,
    input logic pal_wren
);

    int fail_count = 0; // failed properties so far, polled by the testbench

    // deselect turns the output driver off one edge later
    a_oe_off_after_cs : assert property (@(posedge sclk) disable iff (rst) cs |=> !data_oe)
        else
        begin
            $error("data_oe still high after cs rose");
            fail_count++;
        end

    a_single_write : assert property (@(posedge sclk) disable iff (rst) !(rgb_wren && pal_wren))
        else
        begin
            $error("framebuffer and palette written together");
            fail_count++;
        end

    a_oe_off_in_reset : assert property (@(posedge sclk) rst |=> !data_oe)
        else
        begin
            $error("data_oe high during reset");
            fail_count++;
        end

endmodule

bind spi_gpu_top spi_gpu_props u_props (
    .sclk     (sclk),
    .rst      (rst),
    .cs       (cs),
    .data_oe  (data_oe),
    .rgb_wren (rgb_wren),
    .pal_wren (pal_wren)
);

/* rtl/spi_gpu_top.sv */
module spi_gpu_top #(
    parameter int FRAME_PIXELS = 76800,
    parameter int DUMMY_CYCLES = 2
) (
    input  logic                   sclk,
    input  logic                   rst,
    input  logic                   cs,        // high means deselected
    input  logic [3:0]             data_in,
    output logic [3:0]             data_out,
    output logic                   data_oe,   // drives the external tristate
    output gpu_spi_pkg::rgb_addr_t rgb_addr,
    output gpu_spi_pkg::pixel_t    rgb_data,
    output logic                   rgb_wren,
    output gpu_spi_pkg::pal_addr_t pal_addr,
    output gpu_spi_pkg::color_t    pal_wdata,
    output logic                   pal_wren,
    input  gpu_spi_pkg::color_t    pal_rdata,
    input  logic                   hblank,
    input  logic                   vblank
);

    spi_phase_if bus ();

    spi_link #(
        .DUMMY_CYCLES(DUMMY_CYCLES)
    ) u_link (
        .sclk     (sclk),
        .rst      (rst),
        .cs       (cs),
        .data_in  (data_in),
        .data_out (data_out),
        .data_oe  (data_oe),
        .bus      (bus.link)
    );

    palette_port u_palette (
        .sclk      (sclk),
        .rst       (rst),
        .bus       (bus.palette),
        .pal_addr  (pal_addr),
        .pal_wdata (pal_wdata),
        .pal_wren  (pal_wren),
        .pal_rdata (pal_rdata)
    );

    pixel_writer #(
        .FRAME_PIXELS(FRAME_PIXELS)
    ) u_pixel (
        .sclk     (sclk),
        .rst      (rst),
        .bus      (bus.pixel),
        .rgb_addr (rgb_addr),
        .rgb_data (rgb_data),
        .rgb_wren (rgb_wren)
    );

    status_ctrl u_status (
        .sclk   (sclk),
        .rst    (rst),
        .bus    (bus.status),
        .hblank (hblank),
        .vblank (vblank)
    );

endmodule

/* rtl/status_ctrl.sv */
module status_ctrl (
    input  logic        sclk,
    input  logic        rst,
    spi_phase_if.status bus,
    input  logic        hblank,
    input  logic        vblank
);
    import gpu_spi_pkg::*;

    logic    output_enabled;
    status_t status_word;
    logic    stat_load;
    logic    stat_shift;

    assign status_word = {STATUS_TAG, hblank, vblank, output_enabled};
    assign stat_load   = bus.wr_prep & bus.sel.status;  // snapshot before transmit
    assign stat_shift  = bus.wr_shift & bus.sel.status;

    // survives cs, only rst clears it
    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            output_enabled <= 1'b0;
        end
        else if (bus.cmd_done)
        begin
            if (bus.sel.enable_out)
                output_enabled <= 1'b1;
            else if (bus.sel.disable_out)
                output_enabled <= 1'b0;
        end
    end

    nibble_ser #(
        .payload_t(status_t)
    ) u_ser (
        .sclk   (sclk),
        .rst    (rst),
        .load   (stat_load),
        .word   (status_word),
        .shift  (stat_shift),
        .nibble (bus.stat_tx)
    );

endmodule

/* rtl/pixel_writer.sv */
module pixel_writer #(
    parameter int FRAME_PIXELS = 76800
) (
    input  logic                   sclk,
    input  logic                   rst,
    spi_phase_if.pixel             bus,
    output gpu_spi_pkg::rgb_addr_t rgb_addr,
    output gpu_spi_pkg::pixel_t    rgb_data,
    output logic                   rgb_wren
);
    import gpu_spi_pkg::*;

    logic           addr_done;  // start address received
    logic           clear;
    logic           addr_valid;
    logic           pix_valid;
    rgb_addr_wire_t addr_word;
    logic           addr_full;
    pixel_t         pix_word;
    logic           pix_full;

    assign clear      = ~bus.sel.pixel;
    assign addr_valid = bus.rx_valid & bus.sel.pixel & ~addr_done;
    assign pix_valid  = bus.rx_valid & bus.sel.pixel & addr_done;

    nibble_deser #(
        .payload_t(rgb_addr_wire_t)
    ) u_addr_deser (
        .sclk   (sclk),
        .rst    (rst),
        .clear  (clear),
        .nibble (bus.rx_nibble),
        .valid  (addr_valid),
        .word   (addr_word),
        .full   (addr_full)
    );

    nibble_deser #(
        .payload_t(pixel_t)
    ) u_pix_deser (
        .sclk   (sclk),
        .rst    (rst),
        .clear  (clear),
        .nibble (bus.rx_nibble),
        .valid  (pix_valid),
        .word   (pix_word),
        .full   (pix_full)
    );

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            addr_done <= 1'b0;
            rgb_wren  <= 1'b0;
        end
        else
        begin
            rgb_wren <= pix_full;
            if (clear)
                addr_done <= 1'b0;
            else if (addr_full)
                addr_done <= 1'b1;
        end
    end

    always_ff @(posedge sclk)
    begin
        if (addr_full)
            rgb_addr <= rgb_addr_t'(addr_word); // upper wire bits ignored
        else if (rgb_wren)
            rgb_addr <= (rgb_addr == rgb_addr_t'(FRAME_PIXELS - 1)) ? '0 : rgb_addr + 1'b1;
        if (pix_full)
            rgb_data <= pix_word;
    end

endmodule

/* rtl/palette/palette_port.sv */
module palette_port (
    input  logic                   sclk,
    input  logic                   rst,
    spi_phase_if.palette           bus,
    output gpu_spi_pkg::pal_addr_t pal_addr,
    output gpu_spi_pkg::color_t    pal_wdata,
    output logic                   pal_wren,
    input  gpu_spi_pkg::color_t    pal_rdata
);
    import gpu_spi_pkg::*;

    localparam int COLOR_NIBBLES = $bits(color_t) / NIBBLE_W;
    localparam int NIB_W         = $clog2(COLOR_NIBBLES);

    pal_addr_t        wr_idx;
    pal_addr_t        rd_idx;   // index of the next colour to load
    color_t           set_word;
    logic             set_full;
    logic             set_valid;
    logic             set_clear;
    logic             get_load;
    logic             get_shift;
    logic [NIB_W-1:0] nib_cnt;  // position inside the colour being sent

    assign set_valid = bus.rx_valid & bus.sel.pal_set;
    assign set_clear = ~bus.sel.pal_set;

    nibble_deser #(
        .payload_t(color_t)
    ) u_deser (
        .sclk   (sclk),
        .rst    (rst),
        .clear  (set_clear),
        .nibble (bus.rx_nibble),
        .valid  (set_valid),
        .word   (set_word),
        .full   (set_full)
    );

    // colour 0 loads on wr_prep, each next one as the last nibble shifts out
    assign get_shift = bus.wr_shift & bus.sel.pal_get;
    assign get_load  = bus.sel.pal_get
                     & (bus.wr_prep | (bus.wr_shift & (nib_cnt == NIB_W'(COLOR_NIBBLES - 1))));

    nibble_ser #(
        .payload_t(color_t)
    ) u_ser (
        .sclk   (sclk),
        .rst    (rst),
        .load   (get_load),
        .word   (pal_rdata),
        .shift  (get_shift),
        .nibble (bus.pal_tx)
    );

    // read index idles at 0 so colour 0 is already out of the RAM at wr_prep
    assign pal_addr = pal_wren ? wr_idx : rd_idx;

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            pal_wren <= 1'b0;
            wr_idx   <= '0;
            rd_idx   <= '0;
            nib_cnt  <= '0;
        end
        else
        begin
            pal_wren <= set_full;
            if (!bus.sel.pal_set)
                wr_idx <= '0;
            else if (pal_wren)
                wr_idx <= wr_idx + 1'b1; // step after each write, wraps after 255
            if (!bus.sel.pal_get)
            begin
                rd_idx  <= '0;
                nib_cnt <= '0;
            end
            else
            begin
                if (get_load)
                    rd_idx <= rd_idx + 1'b1; // fetch ahead
                if (get_shift)
                    nib_cnt <= (nib_cnt == NIB_W'(COLOR_NIBBLES - 1)) ? '0 : nib_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sclk)
    begin
        if (set_full)
            pal_wdata <= set_word;
    end

endmodule

/* rtl/spi_link.sv */
module spi_link #(
    parameter int DUMMY_CYCLES = 2
) (
    input  logic       sclk,
    input  logic       rst,
    input  logic       cs,
    input  logic [3:0] data_in,
    output logic [3:0] data_out,
    output logic       data_oe,
    spi_phase_if.link  bus
);
    import gpu_spi_pkg::*;

    localparam int STATUS_NIBBLES = $bits(status_t) / NIBBLE_W;
    localparam int CNT_W          = $clog2(PAL_NIBBLES + DUMMY_CYCLES);

    link_state_t      state;
    link_state_t      state_next;
    logic [CNT_W-1:0] cnt;      // cycles spent in the current state
    logic [3:0]       cmd_hi;   // first command nibble
    command_t         cmd_byte;
    handler_sel_t     sel_d;
    logic             has_rx;
    logic             has_tx;
    logic             sel_tx;   // latched command has a transmit phase
    logic [CNT_W-1:0] tx_last;

    assign cmd_byte = command_t'({cmd_hi, data_in});

    always_comb
    begin
        sel_d = '0;
        case (cmd_byte)
            CMD_FB_WRITE:       sel_d.pixel       = 1'b1;
            CMD_PAL_SET:        sel_d.pal_set     = 1'b1;
            CMD_PAL_GET:        sel_d.pal_get     = 1'b1;
            CMD_READ_STATUS0:   sel_d.status      = 1'b1;
            CMD_ENABLE_OUTPUT:  sel_d.enable_out  = 1'b1;
            CMD_DISABLE_OUTPUT: sel_d.disable_out = 1'b1;
            default:            ;                       // unknown, no handler
        endcase
    end

    assign has_rx  = (|sel_d) & cmd_byte[7];
    assign has_tx  = (|sel_d) & cmd_byte[6];
    assign sel_tx  = bus.sel.pal_get | bus.sel.status;
    assign tx_last = bus.sel.pal_get ? CNT_W'(PAL_NIBBLES - 1) : CNT_W'(STATUS_NIBBLES - 1);

    // the state runs one cycle ahead of the pins in transmit, because data_out
    // is registered, so the last dummy cycle on the pins is already TRANSMIT here
    always_comb
    begin
        state_next = state;
        if (cs)
            state_next = IDLE;
        else
            case (state)
                IDLE:     state_next = COMMAND;
                COMMAND:  state_next = has_rx ? RECEIVE : (has_tx ? DUMMY : DONE);
                RECEIVE:
                begin
                    if (bus.sel.pal_set && cnt == CNT_W'(PAL_NIBBLES - 1))
                        state_next = sel_tx ? DUMMY : DONE; // pixel write runs until cs
                end
                DUMMY:    if (cnt == CNT_W'(DUMMY_CYCLES - 2)) state_next = TRANSMIT;
                TRANSMIT: if (cnt == tx_last) state_next = DONE;
                default:  state_next = DONE;
            endcase
    end

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            state        <= IDLE;
            cnt          <= '0;
            bus.sel      <= '0;
            bus.cmd_done <= 1'b0;
            bus.wr_prep  <= 1'b0;
            data_oe      <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            cnt          <= (state_next == state) ? cnt + 1'b1 : '0;
            bus.cmd_done <= (state == COMMAND) && !cs;
            bus.wr_prep  <= (state_next == DUMMY) && (state != DUMMY);
            data_oe      <= (state == TRANSMIT) && !cs;
            if (cs)
                bus.sel <= '0;
            else if (state == COMMAND)
                bus.sel <= sel_d;
        end
    end

    always_ff @(posedge sclk)
    begin
        if (state == IDLE)
            cmd_hi <= data_in;
        if (state == TRANSMIT)
            data_out <= bus.sel.pal_get ? bus.pal_tx : bus.stat_tx;
    end

    assign bus.rx_nibble = data_in;
    assign bus.rx_valid  = (state == RECEIVE) && !cs;
    assign bus.wr_shift  = (state == TRANSMIT);

endmodule

/* rtl/nibble_ser.sv */
module nibble_ser #(
    parameter type payload_t = logic [7:0]
) (
    input  logic       sclk,
    input  logic       rst,
    input  logic       load,
    input  payload_t   word,
    input  logic       shift,
    output logic [3:0] nibble
);
    import gpu_spi_pkg::*;

    localparam int W = $bits(payload_t);

    logic [W-1:0] sh;

    // front nibble is always the top one
    assign nibble = sh[W-1 -: NIBBLE_W];

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            sh <= '0;
        end
        else if (load)
        begin
            sh <= word; // a load wins over a shift on the same edge
        end
        else if (shift)
        begin
            sh <= sh << NIBBLE_W;
        end
    end

endmodule

/* rtl/nibble_deser.sv */
module nibble_deser #(
    parameter type payload_t = logic [7:0]
) (
    input  logic       sclk,
    input  logic       rst,
    input  logic       clear,
    input  logic [3:0] nibble,
    input  logic       valid,
    output payload_t   word,
    output logic       full
);
    import gpu_spi_pkg::*;

    localparam int W     = $bits(payload_t);
    localparam int N     = W / NIBBLE_W;
    localparam int SH_W  = W - NIBBLE_W;
    localparam int CNT_W = $clog2(N);

    logic [SH_W-1:0]  sh;  // nibbles collected so far, oldest on top
    logic [CNT_W-1:0] cnt;

    // the completing nibble goes straight into word, so full and word line up
    assign word = payload_t'({sh, nibble});
    assign full = valid & (cnt == CNT_W'(N - 1));

    always_ff @(posedge sclk)
    begin
        if (rst || clear)
            cnt <= '0;
        else if (valid)
            cnt <= full ? '0 : cnt + 1'b1;
    end

    always_ff @(posedge sclk)
    begin
        if (valid)
            sh <= SH_W'({sh, nibble}); // drop the oldest nibble
    end

endmodule

/* common/spi_phase_if.sv */
interface spi_phase_if;
    import gpu_spi_pkg::*;

    handler_sel_t        sel;       // held from decode until cs rises
    logic                cmd_done;  // pulse after the second command nibble
    logic [NIBBLE_W-1:0] rx_nibble;
    logic                rx_valid;
    logic                wr_prep;   // first dummy cycle
    logic                wr_shift;
    logic [NIBBLE_W-1:0] pal_tx;
    logic [NIBBLE_W-1:0] stat_tx;

    modport link (
        output sel, cmd_done, rx_nibble, rx_valid, wr_prep, wr_shift,
        input  pal_tx, stat_tx
    );

    modport palette (
        input  sel, rx_nibble, rx_valid, wr_prep, wr_shift,
        output pal_tx
    );

    modport pixel (
        input sel, rx_nibble, rx_valid
    );

    modport status (
        input  sel, cmd_done, wr_prep, wr_shift,
        output stat_tx
    );

endinterface

/* common/gpu_spi_pkg.sv */
package gpu_spi_pkg;

    localparam int NIBBLE_W = 4; // bits moved per sclk on the quad bus

    // bit 7 marks a receive phase, bit 6 a transmit phase
    typedef enum logic [7:0] {
        CMD_DISABLE_OUTPUT = 8'b0000_0000,
        CMD_ENABLE_OUTPUT  = 8'b0000_0001,
        CMD_READ_STATUS0   = 8'b0100_0000,
        CMD_PAL_GET        = 8'b0100_0011,
        CMD_FB_WRITE       = 8'b1000_0010, // address, then pixels until cs rises
        CMD_PAL_SET        = 8'b1000_0011
    } command_t;

    typedef logic [23:0] color_t;
    typedef logic [7:0]  pixel_t;
    typedef logic [16:0] rgb_addr_t;
    typedef logic [7:0]  pal_addr_t;
    typedef logic [23:0] rgb_addr_wire_t; // three bytes on the wire, low 17 bits used
    typedef logic [7:0]  status_t;

    localparam logic [4:0] STATUS_TAG = 5'b10110;

    localparam int PAL_ENTRIES = 256;
    localparam int PAL_NIBBLES = PAL_ENTRIES * $bits(color_t) / NIBBLE_W;

    typedef enum logic [2:0] {
        IDLE,
        COMMAND,
        RECEIVE,
        DUMMY,
        TRANSMIT,
        DONE
    } link_state_t;

    // one bit per handler, all zero for an unknown command
    typedef struct packed {
        logic pixel;
        logic pal_set;
        logic pal_get;
        logic status;
        logic enable_out;
        logic disable_out;
    } handler_sel_t;

endpackage
